//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 64;  // Data and address width

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  localparam reg_addr_t stack_reg = 5'd2;  // Stack pointer register index

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    JAL    = 7'b1101111
  } opcode_e;

  // funct3 encodings
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;  // SUB selector

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same 32-bit word, read through both views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_LINK  // Result is pc+4
  } alu_op_e;

  // IF/ID register
  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_u instr;
  } fetch_s;

  // ID/EX register
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_jump;
    word_t     a;
    word_t     b;
    word_t     imm;
  } issue_s;

  // EX/WB register, also the retire port
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } retire_s;

endpackage

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire core_pkg::word_t  entry,
  output core_pkg::word_t       imem_addr,
  output logic                  imem_req,
  input  wire logic             imem_valid,
  input  wire logic [31:0]      imem_data,
  input  wire logic             take,
  input  wire logic             redirect,
  input  wire core_pkg::word_t  redirect_pc,
  output core_pkg::fetch_s      fetched
);

  core_pkg::word_t pc;
  logic            outstanding;  // Request sent, response not yet back
  logic            discard;      // Drop the response that was in flight at redirect
  logic            issue;
  logic            accept;

  // One request at a time, and only when IF/ID will have room for it
  assign issue  = !outstanding && (!fetched.valid || take) && !redirect;
  assign accept = imem_valid && !discard && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc            <= entry;  // Program entry
      outstanding   <= 1'b0;
      discard       <= 1'b0;
      imem_req      <= 1'b0;
      fetched.valid <= 1'b0;
    end else begin
      imem_req <= issue;  // Strobe for one cycle
      if (issue) begin
        outstanding <= 1'b1;
        pc          <= pc + 64'd4;
      end else if (imem_valid) begin
        outstanding <= 1'b0;
      end
      if (imem_valid)
        discard <= 1'b0;
      if (redirect) begin
        pc <= redirect_pc;
        // Response still pending, so it belongs to the wrong path
        if (outstanding && !imem_valid)
          discard <= 1'b1;
      end
      if (redirect)
        fetched.valid <= 1'b0;  // Flush IF/ID
      else if (accept)
        fetched.valid <= 1'b1;
      else if (take)
        fetched.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue)
      imem_addr <= pc;  // Held until the next request
    if (accept) begin
      fetched.pc    <= imem_addr;
      fetched.instr <= imem_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire core_pkg::fetch_s    fetched,
  output logic                     take,
  input  wire logic                redirect,
  output core_pkg::reg_addr_t      rs1_addr,
  output core_pkg::reg_addr_t      rs2_addr,
  input  wire core_pkg::word_t     rs1_data,
  input  wire core_pkg::word_t     rs2_data,
  input  wire logic                rs1_busy,
  input  wire logic                rs2_busy,
  output logic                     mark_busy,
  output core_pkg::reg_addr_t      busy_rd,
  output core_pkg::issue_s         issued
);

  core_pkg::instr_u    instr;
  core_pkg::alu_op_e   alu_op;
  core_pkg::reg_addr_t rd;
  core_pkg::word_t     i_imm;
  core_pkg::word_t     j_imm;
  core_pkg::word_t     imm;
  logic                use_imm;
  logic                is_jump;
  logic                use_rs1;
  logic                use_rs2;
  logic                src_busy;
  logic                jump_pending;

  assign instr = fetched.instr;
  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  // Immediate from the I view, J immediate scattered over the R view
  assign i_imm = {{52{instr.i.imm12[11]}}, instr.i.imm12};
  assign j_imm = {{44{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                  instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

  always_comb begin
    alu_op  = core_pkg::ALU_ADD;
    rd      = instr.r.rd;
    imm     = i_imm;
    use_imm = 1'b0;
    is_jump = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (instr.r.opcode)
      core_pkg::OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (instr.r.funct3)
          core_pkg::f3_add_sub: begin
            if (instr.r.funct7 == core_pkg::f7_sub)
              alu_op = core_pkg::ALU_SUB;
            else if (instr.r.funct7 != core_pkg::f7_base)
              rd = '0;  // Unknown funct7, no-op
          end
          core_pkg::f3_xor: alu_op = core_pkg::ALU_XOR;
          core_pkg::f3_or:  alu_op = core_pkg::ALU_OR;
          core_pkg::f3_and: alu_op = core_pkg::ALU_AND;
          default:          rd = '0;
        endcase
      end
      core_pkg::OP_IMM: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;  // Only ADDI
        if (instr.i.funct3 != core_pkg::f3_add_sub)
          rd = '0;
      end
      core_pkg::JAL: begin
        alu_op  = core_pkg::ALU_PASS_LINK;
        is_jump = 1'b1;
        imm     = j_imm;
      end
      default: rd = '0;  // Unknown opcode, no-op
    endcase
  end

  // RAW hazard only on sources the format actually reads
  assign src_busy = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
  // Hold younger instructions back until the jump redirects
  assign jump_pending = issued.valid && issued.is_jump;
  assign take = fetched.valid && !src_busy && !redirect && !jump_pending;

  assign mark_busy = take && (rd != '0);
  assign busy_rd   = rd;

  always_ff @(posedge clk) begin
    if (reset)
      issued.valid <= 1'b0;
    else
      issued.valid <= take;
  end

  always_ff @(posedge clk) begin
    if (take) begin
      issued.pc      <= fetched.pc;
      issued.rd      <= rd;
      issued.alu_op  <= alu_op;
      issued.use_imm <= use_imm;
      issued.is_jump <= is_jump;
      issued.a       <= rs1_data;
      issued.b       <= rs2_data;
      issued.imm     <= imm;
    end
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire core_pkg::word_t      stackptr,
  input  wire core_pkg::reg_addr_t  rs1_addr,
  input  wire core_pkg::reg_addr_t  rs2_addr,
  output core_pkg::word_t           rs1_data,
  output core_pkg::word_t           rs2_data,
  output logic                      rs1_busy,
  output logic                      rs2_busy,
  input  wire logic                 mark_busy,
  input  wire core_pkg::reg_addr_t  busy_rd,
  input  wire core_pkg::retire_s    write
);

  core_pkg::word_t regs [32];
  logic [31:0]     busy;  // Scoreboard, one bit per register

  // Reads are combinational, a write shows up next cycle
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];
  assign rs1_busy = busy[rs1_addr];
  assign rs2_busy = busy[rs2_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
      regs[core_pkg::stack_reg] <= stackptr;  // Initial stack pointer
    end else if (write.valid && write.rd != '0) begin
      regs[write.rd] <= write.data;  // x0 never written
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      for (int i = 0; i < 32; i++) begin
        // Mark wins over a write to the same register
        if (mark_busy && busy_rd == i && busy_rd != '0)
          busy[i] <= 1'b1;
        else if (write.valid && write.rd == i)
          busy[i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire core_pkg::issue_s   issued,
  output core_pkg::retire_s       retire,
  output logic                    redirect,
  output core_pkg::word_t         redirect_pc
);

  core_pkg::word_t op_b;
  core_pkg::word_t link;
  core_pkg::word_t target;
  core_pkg::word_t result;

  assign op_b   = issued.use_imm ? issued.imm : issued.b;  // ADDI takes the immediate
  assign link   = issued.pc + 64'd4;
  assign target = issued.pc + issued.imm;  // JAL target

  always_comb begin
    case (issued.alu_op)
      core_pkg::ALU_ADD:       result = issued.a + op_b;
      core_pkg::ALU_SUB:       result = issued.a - op_b;
      core_pkg::ALU_AND:       result = issued.a & op_b;
      core_pkg::ALU_OR:        result = issued.a | op_b;
      core_pkg::ALU_XOR:       result = issued.a ^ op_b;
      core_pkg::ALU_PASS_LINK: result = link;
      default:                 result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
      redirect     <= 1'b0;
    end else begin
      retire.valid <= issued.valid && issued.rd != '0;  // Writes to x0 never retire
      redirect     <= issued.valid && issued.is_jump;   // One cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    retire.rd   <= issued.rd;
    retire.data <= result;
    redirect_pc <= target;
  end

endmodule

`default_nettype wire

//--- logic/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire core_pkg::word_t   entry,
  input  wire core_pkg::word_t   stackptr,
  output logic                   imem_req,
  output core_pkg::word_t        imem_addr,
  input  wire logic              imem_valid,
  input  wire logic [31:0]       imem_data,
  output core_pkg::retire_s      retire
);

  core_pkg::fetch_s    fetched;
  core_pkg::issue_s    issued;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::reg_addr_t busy_rd;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     redirect_pc;
  logic                rs1_busy;
  logic                rs2_busy;
  logic                mark_busy;
  logic                take;
  logic                redirect;

  fetch_unit i_fetch (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_valid  (imem_valid),
    .imem_data   (imem_data),
    .take        (take),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetched     (fetched)
  );

  decode_unit i_decode (
    .clk       (clk),
    .reset     (reset),
    .fetched   (fetched),
    .take      (take),
    .redirect  (redirect),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy),
    .mark_busy (mark_busy),
    .busy_rd   (busy_rd),
    .issued    (issued)
  );

  register_file i_regs (
    .clk       (clk),
    .reset     (reset),
    .stackptr  (stackptr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_busy  (rs1_busy),
    .rs2_busy  (rs2_busy),
    .mark_busy (mark_busy),
    .busy_rd   (busy_rd),
    .write     (retire)  // Write-back is the retire port
  );

  execute_unit i_execute (
    .clk         (clk),
    .reset       (reset),
    .issued      (issued),
    .retire      (retire),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

`default_nettype wire

//--- testbench/core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module core_checker (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               imem_req,
  input  wire logic               imem_valid,
  input  wire logic               redirect,
  input  wire core_pkg::retire_s  retire
);

  logic waiting;  // Request seen, response not back yet

  always_ff @(posedge clk) begin
    if (reset)
      waiting <= 1'b0;
    else if (imem_req)
      waiting <= 1'b1;
    else if (imem_valid)
      waiting <= 1'b0;  // Also covers a discarded response
  end

  // Writes to x0 never show on the retire port
  a_retire_rd: assert property (@(posedge clk) disable iff (reset)
    retire.valid |-> retire.rd != '0)
    else $error("retire.valid with retire.rd equal to 0");

  // One request in flight at a time
  a_one_request: assert property (@(posedge clk) disable iff (reset)
    imem_req |-> !waiting)
    else $error("imem_req raised before imem_valid of the previous request");

  a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !redirect)
    else $error("redirect high for more than one cycle");

endmodule

`default_nettype wire

//--- testbench/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

  localparam int n_instr = 24;  // Program length of every test
  localparam int n_tests = 6;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam int k_alu   = 0;  // Program kinds
  localparam int k_imm   = 1;
  localparam int k_chain = 2;
  localparam int k_jump  = 3;

  // One expected write, with the fetch target when it came from a JAL
  typedef struct packed {
    core_pkg::retire_s wr;
    logic              is_jump;
    core_pkg::word_t   target;
  } expect_s;

  logic              clk;
  logic              reset;
  core_pkg::word_t   entry;
  core_pkg::word_t   stackptr;
  logic              imem_req;
  core_pkg::word_t   imem_addr;
  logic              imem_valid = 1'b0;
  logic [31:0]       imem_data = '0;
  core_pkg::retire_s retire;

  logic [31:0]       lcg_state = 32'd32;  // Seed
  logic [31:0]       prog [n_instr];
  core_pkg::word_t   cur_entry;
  core_pkg::word_t   cur_sp;
  core_pkg::word_t   req_addr;
  logic              fixed_lat;  // Every response after one cycle
  expect_s           exp_q [$];
  core_pkg::retire_s seen_q [$];
  core_pkg::retire_s saved_q [$];  // Retires of the previous test
  int                error_count;
  int                failed_tests;
  int                wait_cnt;
  int                delay;

  core_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .stackptr   (stackptr),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_valid (imem_valid),
    .imem_data  (imem_data),
    .retire     (retire)
  );

  bind core_top core_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .imem_req   (imem_req),
    .imem_valid (imem_valid),
    .redirect   (redirect),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned range);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 8) % range;  // Low bits of an LCG are weak
  endfunction

  function automatic logic [31:0] addi_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, op_imm};
  endfunction

  // ADD, SUB, AND, OR, XOR picked by sel
  function automatic logic [31:0] alu_word(input int sel, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = 7'h00;
    case (sel % 5)
      0:       f3 = 3'b000;
      1: begin
        f3 = 3'b000;
        f7 = 7'h20;
      end
      2:       f3 = 3'b111;
      3:       f3 = 3'b110;
      default: f3 = 3'b100;
    endcase
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};  // J-type scramble
  endfunction

  function automatic void gen_program(input int kind);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev;
    logic [11:0] imm;
    int          sel;
    int          skip;
    prev = 5'd2;  // Chain starts from the stack pointer
    for (int i = 0; i < n_instr; i++) begin
      rd  = 5'(rand_below(32));
      rs1 = 5'(rand_below(32));
      rs2 = 5'(rand_below(32));
      imm = 12'(rand_below(4096));
      sel = int'(rand_below(8));
      case (kind)
        k_alu: prog[i] = (i < 6) ? addi_word(imm, 5'd0, rd) : alu_word(sel, rs1, rs2, rd);
        k_imm: begin
          imm[11] = i[0];  // Alternate the sign
          prog[i] = addi_word(imm, (sel < 4) ? 5'd2 : rs1, rd);
        end
        k_chain: begin
          if (rd == 5'd0)
            rd = 5'd1;
          prog[i] = (sel < 3) ? addi_word(imm, prev, rd)
                              : alu_word(sel, prev, sel[0] ? prev : rs2, rd);
          prev = rd;  // Next one reads this destination
        end
        default: begin
          if (rd == 5'd0)
            rd = 5'd3;
          if (i % 4 == 2) begin
            skip = 1 + int'(rand_below(3));
            if (i + skip > n_instr)
              skip = n_instr - i;  // Land at most on the end of the program
            prog[i] = jal_word(21'(skip * 4), rd);
          end else begin
            prog[i] = (sel < 4) ? addi_word(imm, rs1, rd) : alu_word(sel, rs1, rs2, rd);
          end
        end
      endcase
    end
  endfunction

  // Runs the program on an ISA model and lists the writes in order
  function automatic void model_program(input core_pkg::word_t start, input core_pkg::word_t sp);
    core_pkg::word_t x [32];
    core_pkg::word_t pc;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t res;
    core_pkg::word_t imm;
    logic [31:0]     w;
    expect_s         e;
    int              idx;
    for (int i = 0; i < 32; i++)
      x[i] = '0;
    x[2] = sp;
    exp_q.delete();
    pc  = start;
    idx = 0;
    while (idx < n_instr) begin
      w = prog[idx];
      a = x[w[19:15]];
      b = x[w[24:20]];
      e = '0;
      e.wr.valid = 1'b1;
      e.wr.rd    = w[11:7];
      pc         = pc + 64'd4;  // Default next pc
      if (w[6:0] == op_jal) begin
        imm      = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res      = pc;          // Link value
        e.is_jump = 1'b1;
        e.target = pc - 64'd4 + imm;
        pc       = e.target;
      end else if (w[6:0] == op_imm) begin
        res = a + {{52{w[31]}}, w[31:20]};
      end else begin
        case (w[14:12])
          3'b000:  res = (w[31:25] == 7'h20) ? a - b : a + b;
          3'b111:  res = a & b;
          3'b110:  res = a | b;
          default: res = a ^ b;
        endcase
      end
      if (w[11:7] != 5'd0) begin
        x[w[11:7]] = res;
        e.wr.data  = res;
        exp_q.push_back(e);
      end
      idx = int'((pc - start) >> 2);
    end
  endfunction

  // Program inside its range, opcode 0 no-ops elsewhere
  function automatic logic [31:0] mem_word(input core_pkg::word_t addr);
    core_pkg::word_t off;
    logic [31:0]     fold;
    off  = addr - cur_entry;
    fold = addr[63:32] ^ addr[31:0];
    if (addr >= cur_entry && off < 64'(n_instr * 4))
      return prog[off[31:2]];
    else
      return {fold[31:7] ^ {18'd0, fold[6:0]}, 7'd0};
  endfunction

  // Instruction memory, one response per request after 1 to 4 cycles
  always @(posedge clk) begin
    imem_valid <= 1'b0;
    if (reset) begin
      wait_cnt <= 0;
    end else if (imem_req) begin
      delay = fixed_lat ? 1 : 1 + int'(rand_below(4));
      req_addr <= imem_addr;
      if (delay == 1) begin
        imem_valid <= 1'b1;
        imem_data  <= mem_word(imem_addr);
      end else begin
        wait_cnt <= delay - 1;
      end
    end else if (wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
      if (wait_cnt == 1) begin
        imem_valid <= 1'b1;
        imem_data  <= mem_word(req_addr);
      end
    end
  end

  task automatic check_retire(input core_pkg::retire_s got, input core_pkg::retire_s exp);
    if (got !== exp) begin
      $display("** Error: retire rd %h data %h, expected rd %h data %h",
               got.rd, got.data, exp.rd, exp.data);
      error_count++;
    end
  endtask

  task automatic check_word(input string name, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Compare process, pops one expected write per retire
  initial begin
    expect_s         e;
    logic            armed;  // Waiting for the fetch after a JAL
    core_pkg::word_t want;
    armed = 1'b0;
    forever begin
      @(negedge clk);
      if (reset) begin
        armed = 1'b0;
      end else begin
        if (armed && imem_req) begin
          check_word("imem_addr", imem_addr, want);
          armed = 1'b0;
        end
        if (retire.valid) begin
          seen_q.push_back(retire);
          if (exp_q.size() == 0) begin
            $display("Retire of register %0d when no write was left to expect", retire.rd);
            error_count++;
          end else begin
            e = exp_q.pop_front();
            check_retire(retire, e.wr);
            armed = e.is_jump;
            want  = e.target;
          end
        end
      end
    end
  end

  task automatic run_test(input string name, input int kind, input logic fixed,
                          input logic again);
    int errs_before;
    errs_before = error_count;
    @(posedge clk);
    reset     <= 1'b1;
    fixed_lat <= fixed;
    @(negedge clk);
    if (!again) begin  // A repeat run keeps program, entry and stack pointer
      gen_program(kind);
      cur_entry = 64'h8000_0000 + 64'(rand_below(256)) * 64'h1000;
      cur_sp    = {lcg_next(), 32'h0};
      cur_sp[31:0] = lcg_next() & 32'hffff_fff0;
    end
    model_program(cur_entry, cur_sp);
    seen_q.delete();
    @(posedge clk);
    entry    <= cur_entry;
    stackptr <= cur_sp;
    repeat (7) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!imem_req) begin
      if (retire.valid) begin
        $display("Retire seen before the first fetch in %s", name);
        error_count++;
      end
      @(negedge clk);
    end
    check_word("imem_addr", imem_addr, cur_entry);  // First fetch from entry
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (16) @(negedge clk);  // Room for a stray retire or the last jump fetch
    if (again) begin
      if (seen_q.size() != saved_q.size()) begin
        $display("%0d writes retired, but %0d with a fixed latency", seen_q.size(),
                 saved_q.size());
        error_count++;
      end else begin
        foreach (seen_q[j])
          check_retire(seen_q[j], saved_q[j]);
      end
    end
    saved_q = seen_q;
    if (error_count == errs_before) begin
      $display("test %s: ok, %0d writes retired", name, seen_q.size());
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // Watchdog, 40 cycles per instruction with a margin of 4
  initial begin
    repeat (n_tests * n_instr * 40 * 4) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", n_tests * n_instr * 160);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    entry        = '0;
    stackptr     = '0;
    fixed_lat    = 1'b0;
    error_count  = 0;
    failed_tests = 0;
    run_test("alu_random", k_alu, 1'b0, 1'b0);
    run_test("addi_sign", k_imm, 1'b0, 1'b0);
    run_test("raw_chain", k_chain, 1'b0, 1'b0);
    run_test("jal_skip", k_jump, 1'b0, 1'b0);
    run_test("latency_fixed", k_jump, 1'b1, 1'b0);
    run_test("latency_random", k_jump, 1'b0, 1'b1);  // Same program as before
    $display("%0d tests, %0d failed, %0d errors", n_tests, failed_tests, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/core_top.sv
testbench/core_checker.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module core_tb -o core_sim
./obj_dir/core_sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"
